//--- files.f
source/wb2sdr_pkg.sv
source/sync_fifo.sv
source/wb_req_decode.sv
source/sdr_cmd_issue.sv
source/wb2sdr_top.sv
tests/tb_wb2sdr_asserts.sv
tests/tb_wb2sdr.sv

//--- run.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_wb2sdr -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_wb2sdr +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation run ended with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  echo "No pass line found in sim.log"
  exit 1
fi
exit 0

//--- source/sdr_cmd_issue.sv
`timescale 1ns/10ps
`default_nettype none

module sdr_cmd_issue (
  input  wire logic                 sdram_clk,
  input  wire logic                 wb_clk_i,
  input  wire logic                 cmd_push_i,
  input  wire wb2sdr_pkg::sdr_cmd_t cmd_word_i,
  input  wire logic                 wr_push_i,
  input  wire wb2sdr_pkg::wr_beat_t wr_word_i,
  output logic                      cmd_full_o,
  output logic                      wr_full_o,
  output logic                      sdr_req_o,
  output wb2sdr_pkg::sdr_cmd_t      sdr_cmd_o,
  input  wire logic                 sdr_req_ack_i,
  output wb2sdr_pkg::wr_beat_t      sdr_wr_o,
  input  wire logic                 sdr_wr_next_i
);

  logic cmd_empty;

  // ----------------------------------------
  // Command queue
  // ----------------------------------------
  // Controller pops a command with its request ack
  sync_fifo #(
    .WIDTH ($bits(wb2sdr_pkg::sdr_cmd_t)),
    .DEPTH (wb2sdr_pkg::CMD_DEPTH)
  ) u_cmdfifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (cmd_push_i),
    .push_data_i (cmd_word_i),
    .pop_i       (sdr_req_ack_i),
    .pop_data_o  (sdr_cmd_o),
    .full_o      (cmd_full_o),
    .empty_o     (cmd_empty)
  );

  // Request stays up while any command waits
  assign sdr_req_o = !cmd_empty;

  // ----------------------------------------
  // Write data queue
  // ----------------------------------------
  // One beat leaves per next-write strobe
  // Empty flag not needed, controller only strobes after a write command
  sync_fifo #(
    .WIDTH ($bits(wb2sdr_pkg::wr_beat_t)),
    .DEPTH (wb2sdr_pkg::WR_DEPTH)
  ) u_wrdatafifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (wr_push_i),
    .push_data_i (wr_word_i),
    .pop_i       (sdr_wr_next_i),
    .pop_data_o  (sdr_wr_o),
    .full_o      (wr_full_o),
    .empty_o     ()
  );

endmodule

`default_nettype wire

//--- source/sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  wire logic             sdram_clk,
  input  wire logic             wb_clk_i,
  input  wire logic             push_i,
  input  wire logic [WIDTH-1:0] push_data_i,
  input  wire logic             pop_i,
  output logic      [WIDTH-1:0] pop_data_o,
  output logic                  full_o,
  output logic                  empty_o
);

  // Pointer and occupancy sized from the depth
  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  // Storage array
  logic [WIDTH-1:0] mem [DEPTH];

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;

  logic do_push;
  logic do_pop;

  // ----------------------------------------
  // Flags and qualified strobes
  // ----------------------------------------
  assign full_o  = (count == cnt_t'(DEPTH));
  assign empty_o = (count == '0);

  // Push into a full FIFO is dropped
  assign do_push = push_i && !full_o;
  // Pop from an empty FIFO is dropped
  assign do_pop  = pop_i && !empty_o;

  // Head entry shown without a register stage
  assign pop_data_o = mem[rd_ptr];

  // ----------------------------------------
  // Storage write
  // ----------------------------------------
  always_ff @(posedge sdram_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at the last entry
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/wb2sdr_pkg.sv
`default_nettype none

package wb2sdr_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;
  // Application word address
  localparam int APP_AW = 26;
  // Burst length field towards the controller
  localparam int LEN_W  = 9;

  // FIFO depths in entries
  localparam int CMD_DEPTH = 4;
  localparam int WR_DEPTH  = 8;
  localparam int RD_DEPTH  = 16;

  // Wishbone incrementing burst cycle type
  localparam logic [2:0] CTI_INCR = 3'b010;

  // Burst lengths handed to the controller
  localparam logic [LEN_W-1:0] BURST_INCR_LEN   = 9'd8;
  localparam logic [LEN_W-1:0] BURST_SINGLE_LEN = 9'd1;

  // ----------------------------------------
  // Bundles
  // ----------------------------------------
  // Wishbone slave request inputs
  typedef struct packed {
    logic              stb;
    logic              cyc;
    logic              we;
    logic [APP_AW-1:0] addr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
    logic [2:0]        cti;
  } wb_req_t;

  // One controller command, wr_n high means read
  typedef struct packed {
    logic [LEN_W-1:0]  len;
    logic              wr_n;
    logic [APP_AW-1:0] addr;
  } sdr_cmd_t;

  // One write beat with active-low byte enables
  typedef struct packed {
    logic [SEL_W-1:0]  en_n;
    logic [DATA_W-1:0] data;
  } wr_beat_t;

endpackage

`default_nettype wire

//--- source/wb2sdr_top.sv
`timescale 1ns/10ps
`default_nettype none

module wb2sdr_top (
  input  wire logic                            sdram_clk,
  input  wire logic                            wb_clk_i,
  // Wishbone slave side
  input  wire wb2sdr_pkg::wb_req_t             wb_req_i,
  output logic                                 wb_ack_o,
  output logic      [wb2sdr_pkg::DATA_W-1:0]   wb_dat_o,
  // SDRAM controller side
  output logic                                 sdr_req_o,
  output wb2sdr_pkg::sdr_cmd_t                 sdr_cmd_o,
  input  wire logic                            sdr_req_ack_i,
  output wb2sdr_pkg::wr_beat_t                 sdr_wr_o,
  input  wire logic                            sdr_wr_next_i,
  input  wire logic                            sdr_rd_valid_i,
  input  wire logic [wb2sdr_pkg::DATA_W-1:0]   sdr_rd_data_i
);

  // Decode to command issue
  logic                 cmd_push;
  wb2sdr_pkg::sdr_cmd_t cmd_word;
  logic                 wr_push;
  wb2sdr_pkg::wr_beat_t wr_word;
  logic                 cmd_full;
  logic                 wr_full;

  // Read return path
  logic                 rd_empty;
  logic                 rd_pop;

  // ----------------------------------------
  // Wishbone request decode
  // ----------------------------------------
  wb_req_decode u_decode (
    .sdram_clk  (sdram_clk),
    .wb_clk_i   (wb_clk_i),
    .wb_req_i   (wb_req_i),
    .cmd_full_i (cmd_full),
    .wr_full_i  (wr_full),
    .rd_empty_i (rd_empty),
    .wb_ack_o   (wb_ack_o),
    .cmd_push_o (cmd_push),
    .cmd_word_o (cmd_word),
    .wr_push_o  (wr_push),
    .wr_word_o  (wr_word),
    .rd_pop_o   (rd_pop)
  );

  // ----------------------------------------
  // Command and write data towards SDRAM
  // ----------------------------------------
  sdr_cmd_issue u_issue (
    .sdram_clk     (sdram_clk),
    .wb_clk_i      (wb_clk_i),
    .cmd_push_i    (cmd_push),
    .cmd_word_i    (cmd_word),
    .wr_push_i     (wr_push),
    .wr_word_i     (wr_word),
    .cmd_full_o    (cmd_full),
    .wr_full_o     (wr_full),
    .sdr_req_o     (sdr_req_o),
    .sdr_cmd_o     (sdr_cmd_o),
    .sdr_req_ack_i (sdr_req_ack_i),
    .sdr_wr_o      (sdr_wr_o),
    .sdr_wr_next_i (sdr_wr_next_i)
  );

  // ----------------------------------------
  // Read data return
  // ----------------------------------------
  // Only one read in flight, so this never fills
  sync_fifo #(
    .WIDTH (wb2sdr_pkg::DATA_W),
    .DEPTH (wb2sdr_pkg::RD_DEPTH)
  ) u_rddatafifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (sdr_rd_valid_i),
    .push_data_i (sdr_rd_data_i),
    .pop_i       (rd_pop),
    .pop_data_o  (wb_dat_o),
    .full_o      (),
    .empty_o     (rd_empty)
  );

endmodule

`default_nettype wire

//--- source/wb_req_decode.sv
`timescale 1ns/10ps
`default_nettype none

module wb_req_decode (
  input  wire logic                sdram_clk,
  input  wire logic                wb_clk_i,
  input  wire wb2sdr_pkg::wb_req_t wb_req_i,
  input  wire logic                cmd_full_i,
  input  wire logic                wr_full_i,
  input  wire logic                rd_empty_i,
  output logic                     wb_ack_o,
  output logic                     cmd_push_o,
  output wb2sdr_pkg::sdr_cmd_t     cmd_word_o,
  output logic                     wr_push_o,
  output wb2sdr_pkg::wr_beat_t     wr_word_o,
  output logic                     rd_pop_o
);

  logic                         req_live;
  logic                         wr_req;
  logic                         rd_req;
  logic                         rd_cmd_ok;
  logic                         pending_rd;
  logic [wb2sdr_pkg::LEN_W-1:0] burst_len;

  // ----------------------------------------
  // Request qualification
  // ----------------------------------------
  assign req_live = wb_req_i.stb && wb_req_i.cyc;
  assign wr_req   = req_live && wb_req_i.we;
  assign rd_req   = req_live && !wb_req_i.we;

  // Write ack needs room in both command and data FIFOs
  // Read ack waits for the returned word
  always_comb begin
    if (wr_req) begin
      wb_ack_o = !cmd_full_i && !wr_full_i;
    end else if (rd_req) begin
      wb_ack_o = !rd_empty_i;
    end else begin
      wb_ack_o = 1'b0;
    end
  end

  // Read command goes out once per read, only when nothing is in flight
  assign rd_cmd_ok = rd_req && rd_empty_i && !cmd_full_i && !pending_rd;

  // ----------------------------------------
  // FIFO strobes
  // ----------------------------------------
  assign cmd_push_o = wr_req ? wb_ack_o : rd_cmd_ok;
  assign wr_push_o  = wr_req && wb_ack_o;
  assign rd_pop_o   = rd_req && wb_ack_o;

  // ----------------------------------------
  // Command and write beat
  // ----------------------------------------
  // Incrementing burst gets 8, everything else a single beat
  assign burst_len = (wb_req_i.cti == wb2sdr_pkg::CTI_INCR) ?
                     wb2sdr_pkg::BURST_INCR_LEN : wb2sdr_pkg::BURST_SINGLE_LEN;

  assign cmd_word_o.len  = burst_len;
  assign cmd_word_o.wr_n = !wb_req_i.we;
  assign cmd_word_o.addr = wb_req_i.addr;

  // Controller wants active-low byte enables
  assign wr_word_o.en_n = ~wb_req_i.sel;
  assign wr_word_o.data = wb_req_i.dat;

  // ----------------------------------------
  // Pending read
  // ----------------------------------------
  // Set when the read command is queued, cleared when its data is acked
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      pending_rd <= 1'b0;
    end else if (rd_cmd_ok) begin
      pending_rd <= 1'b1;
    end else if (rd_pop_o) begin
      pending_rd <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_wb2sdr.sv
`timescale 1ns/10ps
`default_nettype none

module tb_wb2sdr;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_TXN    = 60;

  logic                 sdram_clk = 1'b0;
  logic                 wb_clk_i;
  wb2sdr_pkg::wb_req_t  wb_req;
  logic                 wb_ack;
  logic [31:0]          wb_dat;
  logic                 sdr_req;
  wb2sdr_pkg::sdr_cmd_t sdr_cmd;
  logic                 sdr_req_ack;
  wb2sdr_pkg::wr_beat_t sdr_wr;
  logic                 sdr_wr_next;
  logic                 sdr_rd_valid;
  logic [31:0]          sdr_rd_data;

  // Controller memory and the reference copy
  logic [31:0] model_mem [16];
  logic [31:0] shadow [16];
  logic        hold_ack;
  int          errors;
  int          tests_run;
  int          tests_failed;

  // Expected traffic, in issue order
  wb2sdr_pkg::sdr_cmd_t exp_cmd_q [$];
  wb2sdr_pkg::wr_beat_t exp_beat_q [$];
  logic [31:0]          exp_rd_q [$];

  wb2sdr_top uut (
    .sdram_clk (sdram_clk), .wb_clk_i (wb_clk_i), .wb_req_i (wb_req),
    .wb_ack_o (wb_ack), .wb_dat_o (wb_dat), .sdr_req_o (sdr_req),
    .sdr_cmd_o (sdr_cmd), .sdr_req_ack_i (sdr_req_ack), .sdr_wr_o (sdr_wr),
    .sdr_wr_next_i (sdr_wr_next), .sdr_rd_valid_i (sdr_rd_valid),
    .sdr_rd_data_i (sdr_rd_data)
  );

  always #(CLK_PERIOD / 2) sdram_clk = ~sdram_clk;

  // Reference byte merge, sel bit high writes that byte
  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] data,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    int          b;
    res = old;
    for (b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------------------
  // Wishbone master tasks
  // ----------------------------------------
  task automatic drive_req(input logic we, input logic [25:0] addr, input logic [31:0] dat,
                           input logic [3:0] sel, input logic [2:0] cti);
    wb2sdr_pkg::wb_req_t  r;
    wb2sdr_pkg::sdr_cmd_t c;
    wb2sdr_pkg::wr_beat_t w;
    @(posedge sdram_clk);
    r.stb  = 1'b1;
    r.cyc  = 1'b1;
    r.we   = we;
    r.addr = addr;
    r.dat  = dat;
    r.sel  = sel;
    r.cti  = cti;
    wb_req <= r;
    // Incrementing burst code 3'b010 asks for 8 beats
    c.len  = (cti == 3'b010) ? 9'd8 : 9'd1;
    c.wr_n = !we;
    c.addr = addr;
    exp_cmd_q.push_back(c);
    if (we) begin
      w.en_n = ~sel;
      w.data = dat;
      exp_beat_q.push_back(w);
      shadow[addr[3:0]] = merge_bytes(shadow[addr[3:0]], dat, sel);
    end else begin
      exp_rd_q.push_back(shadow[addr[3:0]]);
    end
  endtask

  // Cycles counted from the first cycle of the request
  task automatic wait_ack(output int cycles);
    cycles = 0;
    do begin
      @(negedge sdram_clk);
      cycles++;
    end while (!wb_ack && cycles < 200);
    if (!wb_ack) begin
      errors++;
      $display("Acknowledge never came for the request pending at %0t", $time);
    end
  endtask

  // Drop the bus, then let the controller drain every queued command
  task automatic settle;
    int n;
    @(posedge sdram_clk);
    wb_req.stb <= 1'b0;
    wb_req.cyc <= 1'b0;
    n = 0;
    while ((exp_cmd_q.size() != 0 || exp_beat_q.size() != 0) && n < 200) begin
      @(negedge sdram_clk);
      n++;
    end
    if (exp_cmd_q.size() != 0 || exp_beat_q.size() != 0) begin
      errors++;
      $display("Controller did not receive all queued commands and beats");
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
    end
    $display("Test %-14s done, %0d errors", name, errors - errs_before);
  endtask

  // ----------------------------------------
  // SDRAM controller model
  // ----------------------------------------
  initial begin : sdram_model
    wb2sdr_pkg::sdr_cmd_t cmd;
    wb2sdr_pkg::wr_beat_t beat;
    int unsigned          wait_cyc;
    int                   b;
    forever begin
      @(posedge sdram_clk);
      if (sdr_req && !hold_ack) begin
        cmd  = sdr_cmd;
        beat = sdr_wr;
        wait_cyc = $urandom % 4;
        repeat (wait_cyc) @(posedge sdram_clk);
        sdr_req_ack <= 1'b1;
        if (!cmd.wr_n) begin
          sdr_wr_next <= 1'b1;
          // Active-low enables select the bytes to store
          for (b = 0; b < 4; b++) begin
            if (!beat.en_n[b]) begin
              model_mem[cmd.addr[3:0]][8*b +: 8] = beat.data[8*b +: 8];
            end
          end
        end
        @(posedge sdram_clk);
        sdr_req_ack <= 1'b0;
        sdr_wr_next <= 1'b0;
        if (cmd.wr_n) begin
          wait_cyc = 1 + $urandom % 4;
          repeat (wait_cyc - 1) @(posedge sdram_clk);
          sdr_rd_valid <= 1'b1;
          sdr_rd_data  <= model_mem[cmd.addr[3:0]];
          @(posedge sdram_clk);
          sdr_rd_valid <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // Checker, mid-cycle sampling
  // ----------------------------------------
  always @(negedge sdram_clk) begin : compare
    wb2sdr_pkg::sdr_cmd_t ec;
    wb2sdr_pkg::wr_beat_t eb;
    logic [31:0]          ed;
    if (sdr_req_ack) begin
      if (exp_cmd_q.size() == 0) begin
        errors++;
        $display("Controller took a command that was never requested");
      end else begin
        ec = exp_cmd_q.pop_front();
        if (sdr_cmd !== ec) begin
          errors++;
          $display("ERROR at %0t: command %h, expected %h", $time, sdr_cmd, ec);
        end
      end
    end
    if (sdr_wr_next) begin
      if (exp_beat_q.size() == 0) begin
        errors++;
        $display("Controller took a write beat that was never written");
      end else begin
        eb = exp_beat_q.pop_front();
        if (sdr_wr !== eb) begin
          errors++;
          $display("ERROR at %0t: write beat %h, expected %h", $time, sdr_wr, eb);
        end
      end
    end
    // Read data must arrive together with its acknowledge
    if (wb_ack && wb_req.stb && wb_req.cyc && !wb_req.we) begin
      ed = exp_rd_q.pop_front();
      if (wb_dat !== ed) begin
        errors++;
        $display("ERROR at %0t: read data %h, expected %h", $time, wb_dat, ed);
      end
    end
  end

  // Watchdog sized from the transaction count
  initial begin : watchdog
    #(NUM_TXN * 40 * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("Simulation FAILED");
    $finish;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : stimulus
    int          cyc;
    int          e0;
    int          i;
    logic        early;
    int unsigned asrt;
    void'($urandom(32'h512a));
    wb_req       = '0;
    sdr_req_ack  = 1'b0;
    sdr_wr_next  = 1'b0;
    sdr_rd_valid = 1'b0;
    sdr_rd_data  = '0;
    hold_ack     = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    wb_clk_i     = 1'b1;
    // Fill pattern from the full word index
    for (i = 0; i < 16; i++) begin
      model_mem[i] = 32'h1357_9bdf ^ (i * 32'h0101_0101);
      shadow[i]    = 32'h1357_9bdf ^ (i * 32'h0101_0101);
    end
    repeat (2) @(posedge sdram_clk);
    wb_clk_i <= 1'b0;

    // Idle outputs after reset
    e0 = errors;
    @(negedge sdram_clk);
    if (sdr_req !== 1'b0 || wb_ack !== 1'b0) begin
      errors++;
      $display("ERROR at %0t: sdr_req %b wb_ack %b after reset", $time, sdr_req, wb_ack);
    end
    finish_test("reset", e0);

    // Classic write, ack in its first cycle
    e0 = errors;
    drive_req(1'b1, 26'h5, 32'hdead_beef, 4'b0101, 3'b000);
    wait_ack(cyc);
    if (cyc != 1) begin
      errors++;
      $display("ERROR at %0t: write ack after %0d cycles", $time, cyc);
    end
    settle();
    finish_test("write", e0);

    // Partial writes merged, then read back
    e0 = errors;
    drive_req(1'b1, 26'h3, 32'h1122_3344, 4'b0011, 3'b000);
    wait_ack(cyc);
    drive_req(1'b1, 26'h3, 32'haabb_ccdd, 4'b1000, 3'b000);
    wait_ack(cyc);
    drive_req(1'b0, 26'h3, 32'h0, 4'hf, 3'b000);
    wait_ack(cyc);
    drive_req(1'b0, 26'h5, 32'h0, 4'hf, 3'b000);
    wait_ack(cyc);
    settle();
    finish_test("read", e0);

    // Burst length from the cycle type
    e0 = errors;
    drive_req(1'b1, 26'h7, 32'h0bad_f00d, 4'hf, 3'b010);
    wait_ack(cyc);
    drive_req(1'b1, 26'h8, 32'hcafe_0001, 4'hf, 3'b111);
    wait_ack(cyc);
    drive_req(1'b0, 26'h7, 32'h0, 4'hf, 3'b010);
    wait_ack(cyc);
    settle();
    finish_test("burst_len", e0);

    // Command FIFO full while the controller holds off
    e0 = errors;
    @(posedge sdram_clk);
    hold_ack <= 1'b1;
    for (i = 0; i < 4; i++) begin
      drive_req(1'b1, 26'(9 + i), 32'h4000_0000 + i, 4'hf, 3'b000);
      wait_ack(cyc);
      if (cyc != 1) begin
        errors++;
        $display("ERROR at %0t: write %0d ack after %0d cycles", $time, i, cyc);
      end
    end
    drive_req(1'b1, 26'hd, 32'h4000_0004, 4'hf, 3'b000);
    early = 1'b0;
    repeat (6) begin
      @(negedge sdram_clk);
      if (wb_ack) begin
        early = 1'b1;
      end
      // Waiting commands keep the request up
      if (sdr_req !== 1'b1) begin
        errors++;
        $display("ERROR at %0t: sdr_req %b with commands waiting", $time, sdr_req);
      end
    end
    if (early) begin
      errors++;
      $display("ERROR at %0t: fifth write acked with the command FIFO full", $time);
    end
    @(posedge sdram_clk);
    hold_ack <= 1'b0;
    wait_ack(cyc);
    settle();
    finish_test("backpressure", e0);

    // Random mix against the reference
    e0 = errors;
    for (i = 0; i < 40; i++) begin
      drive_req(1'($urandom % 2), 26'($urandom % 16), $urandom, 4'($urandom % 16),
                3'($urandom % 8));
      wait_ack(cyc);
    end
    settle();
    finish_test("random", e0);

    asrt = uut.u_decode.u_dec_asserts.fail_cnt
         + uut.u_issue.u_cmdfifo.u_fifo_asserts.fail_cnt
         + uut.u_issue.u_wrdatafifo.u_fifo_asserts.fail_cnt
         + uut.u_rddatafifo.u_fifo_asserts.fail_cnt;
    $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, asrt);
    if (errors == 0 && asrt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_wb2sdr_asserts.sv
`timescale 1ns/10ps
`default_nettype none

// Blocked-request checks, bound to each FIFO and to the decode
module wb2sdr_asserts (
  input wire logic clk_i,
  input wire logic rst_i,
  input wire logic push_i,
  input wire logic full_i,
  input wire logic pop_i,
  input wire logic empty_i
);

  // Read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // No push into a full FIFO, no read command while one is pending
  no_push_full: assert property (@(posedge clk_i) disable iff (rst_i) !(push_i && full_i))
    else begin
      fail_cnt++;
      $error("push while blocked");
    end

  // No pop from an empty FIFO, no read ack without an outstanding read
  no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i) !(pop_i && empty_i))
    else begin
      fail_cnt++;
      $error("pop while empty");
    end

endmodule

// Decode: read commands as they leave on the port, read acks against the pending flag
bind wb_req_decode wb2sdr_asserts u_dec_asserts (
  .clk_i (sdram_clk), .rst_i (wb_clk_i), .push_i (cmd_push_o && cmd_word_o.wr_n),
  .full_i (pending_rd), .pop_i (rd_pop_o), .empty_i (!pending_rd)
);

bind sync_fifo wb2sdr_asserts u_fifo_asserts (
  .clk_i (sdram_clk), .rst_i (wb_clk_i), .push_i (push_i),
  .full_i (full_o), .pop_i (pop_i), .empty_i (empty_o)
);

`default_nettype wire
